/* common/tracking_params.svh */
`ifndef TRACKING_PARAMS_SVH
`define TRACKING_PARAMS_SVH

// Colour classes recognised by the tracker
`define NUM_COLORS 6

// Ranks kept per colour
`define NUM_RANKS 3

`define MAX_HEIGHT 120  // Heights above this count as zero

// Word address of record 0
`define RECORD_BASE 0

`define ADDR_W 18
`define DATA_W 32
`define COUNT_W 16

`endif

/* common/blob_mem_pkg.sv */
`default_nettype none

`include "tracking_params.svh"

package blob_mem_pkg;

	typedef logic [`ADDR_W-1:0] mem_addr_t;
	typedef logic [`DATA_W-1:0] mem_word_t;

	// One request beat toward the word memory
	typedef struct packed {
		mem_addr_t addr;
		logic      write;  // High for a write, no response follows
		mem_word_t wdata;
	} mem_req_t;

	typedef struct packed {
		mem_word_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* common/blob_track_pkg.sv */
`default_nettype none

`include "tracking_params.svh"

package blob_track_pkg;

	typedef logic [2:0] color_t;  // Colour index, tag minus one
	typedef logic [15:0] metric_t;
	typedef logic [`COUNT_W-1:0] rec_idx_t;

	// Blob offered to the ranking table
	typedef struct packed {
		color_t   color;
		metric_t  metric;
		rec_idx_t idx;
	} cand_t;

	// One beat of the output stream
	typedef struct packed {
		color_t      color;
		logic [7:0]  x;
		logic [7:0]  y;
		logic [15:0] size;
	} centroid_t;

	typedef struct packed {
		metric_t  metric;  // Zero marks an empty slot
		rec_idx_t idx;
	} rank_slot_t;

	typedef enum logic [2:0] {IDLE, CLEAR, SCAN, FETCH, DONE} phase_t;

endpackage

`default_nettype wire

/* scan/rank_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tracking_params.svh"

module rank_table import blob_track_pkg::*; (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        clear,
	input  wire cand_t                 cand,
	input  wire                        cand_valid,
	output rank_slot_t [`NUM_COLORS-1:0] winners
);

	// Per colour, rank 0 holds the best metric
	rank_slot_t [`NUM_COLORS-1:0][`NUM_RANKS-1:0] slots;
	logic [`NUM_RANKS-1:0] beats;
	rank_slot_t new_slot;

	assign new_slot = '{metric: cand.metric, idx: cand.idx};

	// Strictly greater, so an equal metric keeps the earlier record
	always_comb begin
		for (int r = 0; r < `NUM_RANKS; r++) begin
			beats[r] = cand.metric > slots[cand.color][r].metric;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			slots <= '0;
		end else if (cand_valid) begin
			if (beats[0]) begin
				slots[cand.color][0] <= new_slot;
			end
			for (int r = 1; r < `NUM_RANKS; r++) begin
				if (beats[r]) begin
					// Shift down below the insertion point
					slots[cand.color][r] <= beats[r-1] ? slots[cand.color][r-1] : new_slot;
				end
			end
		end
	end

	always_comb begin
		for (int c = 0; c < `NUM_COLORS; c++) begin
			winners[c] = slots[c][0];
		end
	end

endmodule

`default_nettype wire

/* scan/blob_scanner.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tracking_params.svh"

module blob_scanner import blob_mem_pkg::*, blob_track_pkg::*; (
	input  wire           clk,
	input  wire           rst,
	input  wire           scan_go,
	input  wire rec_idx_t blob_count,
	input  wire           mode,  // 0 ranks by size, 1 by height
	input  wire metric_t  min_size,
	output mem_req_t      req,
	output logic          req_valid,
	input  wire           req_ready,
	input  wire mem_rsp_t rsp,
	input  wire           rsp_valid,
	output cand_t         cand,
	output logic          cand_valid,
	output logic          scan_done
);

	typedef enum logic [2:0] {
		SC_IDLE, SC_TAG_REQ, SC_TAG_WAIT, SC_SIZE_REQ, SC_SIZE_WAIT
	} scan_state_t;

	scan_state_t state;
	rec_idx_t idx;
	mem_addr_t rec_addr;  // Word 0 of the current record
	color_t color;
	logic rd_pend;
	logic [7:0] tag;
	logic [7:0] height;
	metric_t metric;

	always_comb begin
		tag = rsp.rdata[7:0];
		height = rsp.rdata[23:16];
		if (mode) begin
			metric = (height > 8'(`MAX_HEIGHT)) ? '0 : metric_t'(height);
		end else begin
			metric = rsp.rdata[15:0];
		end
	end

	always_comb begin
		req.addr = (state == SC_SIZE_REQ) ? rec_addr + mem_addr_t'(1) : rec_addr;
		req.write = 1'b0;
		req.wdata = '0;
	end

	assign req_valid = ((state == SC_TAG_REQ) && (idx != blob_count)) ||
		(state == SC_SIZE_REQ);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SC_IDLE;
			scan_done <= 1'b0;
			cand_valid <= 1'b0;
		end else begin
			scan_done <= 1'b0;
			cand_valid <= 1'b0;
			case (state)
				SC_IDLE: if (scan_go) begin
					idx <= '0;
					rec_addr <= mem_addr_t'(`RECORD_BASE);
					state <= SC_TAG_REQ;
				end
				SC_TAG_REQ: if (idx == blob_count) begin
					scan_done <= 1'b1;
					state <= SC_IDLE;
				end else if (req_ready) begin
					state <= SC_TAG_WAIT;
				end
				SC_TAG_WAIT: if (rsp_valid) begin
					if (tag == 8'd0 || tag > 8'(`NUM_COLORS)) begin  // Unrecognised, skip
						idx <= idx + rec_idx_t'(1);
						rec_addr <= rec_addr + mem_addr_t'(3);
						state <= SC_TAG_REQ;
					end else begin
						color <= color_t'(tag - 8'd1);
						state <= SC_SIZE_REQ;
					end
				end
				SC_SIZE_REQ: if (req_ready) state <= SC_SIZE_WAIT;
				SC_SIZE_WAIT: if (rsp_valid) begin
					cand_valid <= (metric > min_size);
					cand <= '{color: color, metric: metric, idx: idx};
					idx <= idx + rec_idx_t'(1);
					rec_addr <= rec_addr + mem_addr_t'(3);
					state <= SC_TAG_REQ;
				end
				default: state <= SC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_pend <= 1'b0;
		end else if (req_valid && req_ready) begin
			rd_pend <= 1'b1;
		end else if (rsp_valid) begin
			rd_pend <= 1'b0;
		end
	end

	a_one_read: assert property (@(posedge clk) disable iff (rst)
		(req_valid && req_ready) |-> !rd_pend);

endmodule

`default_nettype wire

/* src/tracker_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tracker_ctrl import blob_mem_pkg::*, blob_track_pkg::*; (
	input  wire           clk,
	input  wire           rst,
	input  wire           start,
	output logic          done,
	output logic          clear,
	output logic          scan_go,
	input  wire           scan_done,
	output logic          fetch_go,
	input  wire           fetch_done,
	input  wire mem_req_t scan_req,
	input  wire           scan_req_valid,
	output logic          scan_req_ready,
	output mem_rsp_t      scan_rsp,
	output logic          scan_rsp_valid,
	input  wire mem_req_t fetch_req,
	input  wire           fetch_req_valid,
	output logic          fetch_req_ready,
	output mem_rsp_t      fetch_rsp,
	output logic          fetch_rsp_valid,
	output mem_req_t      mem_req,
	output logic          mem_req_valid,
	input  wire           mem_req_ready,
	input  wire mem_rsp_t mem_rsp,
	input  wire           mem_rsp_valid
);

	phase_t state;
	phase_t state_q;  // Phase of the previous cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			state_q <= IDLE;
			clear <= 1'b0;
			scan_go <= 1'b0;
			fetch_go <= 1'b0;
		end else begin
			state_q <= state;
			// Each pulse fires one cycle after its phase is entered
			clear <= (state == CLEAR) && (state_q != CLEAR);
			scan_go <= (state == SCAN) && (state_q != SCAN);
			fetch_go <= (state == FETCH) && (state_q != FETCH);
			case (state)
				IDLE:    if (start) state <= CLEAR;
				CLEAR:   state <= SCAN;
				SCAN:    if (scan_done) state <= FETCH;
				FETCH:   if (fetch_done) state <= DONE;
				DONE:    if (!start) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign done = (state == DONE);

	// Memory port belongs to the active phase
	assign mem_req = (state == FETCH) ? fetch_req : scan_req;
	assign mem_req_valid = ((state == SCAN) && scan_req_valid) ||
		((state == FETCH) && fetch_req_valid);
	assign scan_req_ready = (state == SCAN) && mem_req_ready;
	assign fetch_req_ready = (state == FETCH) && mem_req_ready;

	assign scan_rsp = mem_rsp;
	assign scan_rsp_valid = (state == SCAN) && mem_rsp_valid;
	assign fetch_rsp = mem_rsp;
	assign fetch_rsp_valid = (state == FETCH) && mem_rsp_valid;

	// Neither block asks for the memory outside a run
	a_quiet_port: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE || state == DONE) |-> !(scan_req_valid || fetch_req_valid));

endmodule

`default_nettype wire

/* src/centroid_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tracking_params.svh"

module centroid_fetch import blob_mem_pkg::*, blob_track_pkg::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          fetch_go,
	input  wire rank_slot_t [`NUM_COLORS-1:0] winners,
	output mem_req_t                     req,
	output logic                         req_valid,
	input  wire                          req_ready,
	input  wire mem_rsp_t                rsp,
	input  wire                          rsp_valid,
	output centroid_t                    cent,
	output logic                         cent_valid,
	input  wire                          cent_ready,
	output logic                         fetch_done
);

	typedef enum logic [2:0] {
		FE_IDLE, FE_SELECT, FE_READ, FE_READ_WAIT, FE_SEND, FE_WRITE
	} fetch_state_t;

	fetch_state_t state;
	color_t color;
	mem_addr_t cent_addr;  // Centroid word of the current winner
	mem_word_t cent_word;

	always_comb begin
		req.addr = cent_addr;
		req.write = (state == FE_WRITE);
		req.wdata = {cent_word[`DATA_W-1:16], 16'h0000};  // Size cleared marks it consumed
	end

	assign req_valid = (state == FE_READ) || (state == FE_WRITE);
	assign cent_valid = (state == FE_SEND);

	always_comb begin
		cent.color = color;
		cent.x = cent_word[31:24];
		cent.y = cent_word[23:16];
		cent.size = cent_word[15:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FE_IDLE;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				FE_IDLE: if (fetch_go) begin
					color <= '0;
					state <= FE_SELECT;
				end
				FE_SELECT: if (color == color_t'(`NUM_COLORS)) begin
					fetch_done <= 1'b1;
					state <= FE_IDLE;
				end else if (winners[color].metric == '0) begin  // No blob for this colour
					color <= color + color_t'(1);
				end else begin
					cent_addr <= mem_addr_t'(`RECORD_BASE) +
						mem_addr_t'(winners[color].idx) * mem_addr_t'(3) + mem_addr_t'(2);
					state <= FE_READ;
				end
				FE_READ: if (req_ready) state <= FE_READ_WAIT;
				FE_READ_WAIT: if (rsp_valid) begin
					cent_word <= rsp.rdata;
					state <= FE_SEND;
				end
				FE_SEND: if (cent_ready) state <= FE_WRITE;
				FE_WRITE: if (req_ready) begin
					color <= color + color_t'(1);
					state <= FE_SELECT;
				end
				default: state <= FE_IDLE;
			endcase
		end
	end

	a_cent_hold: assert property (@(posedge clk) disable iff (rst)
		(cent_valid && !cent_ready) |=> (cent_valid && $stable(cent)));

endmodule

`default_nettype wire

/* src/blob_tracker_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tracking_params.svh"

module blob_tracker_top import blob_mem_pkg::*, blob_track_pkg::*; (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   start,
	output logic                  done,
	input  wire rec_idx_t         blob_count,
	input  wire                   mode,
	input  wire metric_t          min_size,
	output mem_req_t              mem_req,
	output logic                  mem_req_valid,
	input  wire                   mem_req_ready,
	input  wire mem_rsp_t         mem_rsp,
	input  wire                   mem_rsp_valid,
	output centroid_t             cent,
	output logic                  cent_valid,
	input  wire                   cent_ready
);

	logic clear;
	logic scan_go;
	logic scan_done;
	logic fetch_go;
	logic fetch_done;
	mem_req_t scan_req;
	logic scan_req_valid;
	logic scan_req_ready;
	mem_rsp_t scan_rsp;
	logic scan_rsp_valid;
	mem_req_t fetch_req;
	logic fetch_req_valid;
	logic fetch_req_ready;
	mem_rsp_t fetch_rsp;
	logic fetch_rsp_valid;
	cand_t cand;
	logic cand_valid;
	rank_slot_t [`NUM_COLORS-1:0] winners;

	tracker_ctrl u_tracker_ctrl (
		.clk(clk),
		.rst(rst),
		.start(start),
		.done(done),
		.clear(clear),
		.scan_go(scan_go),
		.scan_done(scan_done),
		.fetch_go(fetch_go),
		.fetch_done(fetch_done),
		.scan_req(scan_req),
		.scan_req_valid(scan_req_valid),
		.scan_req_ready(scan_req_ready),
		.scan_rsp(scan_rsp),
		.scan_rsp_valid(scan_rsp_valid),
		.fetch_req(fetch_req),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req_ready(fetch_req_ready),
		.fetch_rsp(fetch_rsp),
		.fetch_rsp_valid(fetch_rsp_valid),
		.mem_req(mem_req),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_rsp(mem_rsp),
		.mem_rsp_valid(mem_rsp_valid)
	);

	blob_scanner u_blob_scanner (
		.clk(clk),
		.rst(rst),
		.scan_go(scan_go),
		.blob_count(blob_count),
		.mode(mode),
		.min_size(min_size),
		.req(scan_req),
		.req_valid(scan_req_valid),
		.req_ready(scan_req_ready),
		.rsp(scan_rsp),
		.rsp_valid(scan_rsp_valid),
		.cand(cand),
		.cand_valid(cand_valid),
		.scan_done(scan_done)
	);

	rank_table u_rank_table (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.cand(cand),
		.cand_valid(cand_valid),
		.winners(winners)
	);

	centroid_fetch u_centroid_fetch (
		.clk(clk),
		.rst(rst),
		.fetch_go(fetch_go),
		.winners(winners),
		.req(fetch_req),
		.req_valid(fetch_req_valid),
		.req_ready(fetch_req_ready),
		.rsp(fetch_rsp),
		.rsp_valid(fetch_rsp_valid),
		.cent(cent),
		.cent_valid(cent_valid),
		.cent_ready(cent_ready),
		.fetch_done(fetch_done)
	);

endmodule

`default_nettype wire

/* dv/blob_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module blob_mem_model import blob_mem_pkg::*; #(
	parameter int AW = 6
) (
	input  wire           clk,
	input  wire           rst,
	input  wire mem_req_t req,
	input  wire           req_valid,
	output logic          req_ready,
	output mem_rsp_t      rsp,
	output logic          rsp_valid
);

	mem_word_t mem [2**AW];  // Preloaded by the testbench
	logic [15:0] lfsr = 16'd34;
	logic ready_r = 1'b0;
	logic valid_r = 1'b0;
	mem_word_t data_r = '0;
	logic pend = 1'b0;  // Read accepted, response not yet sent
	int delay = 0;
	int stall = 0;
	logic xfer = 1'b0;
	mem_req_t req_s = '0;

	assign req_ready = ready_r;
	assign rsp_valid = valid_r;
	assign rsp.rdata = data_r;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	task automatic draw(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	always @(posedge clk) begin
		xfer = req_valid && req_ready;
		req_s = req;
		#1;
		valid_r = 1'b0;
		if (rst) begin
			pend = 1'b0;
			ready_r = 1'b0;
		end else begin
			if (pend && delay == 0) begin
				valid_r = 1'b1;
				pend = 1'b0;
			end else if (pend) begin
				delay--;
			end
			if (xfer && req_s.write) begin
				mem[req_s.addr[AW-1:0]] = req_s.wdata;
			end else if (xfer) begin
				data_r = mem[req_s.addr[AW-1:0]];
				pend = 1'b1;
				draw(2, delay);  // Extra latency of 0 to 3 cycles
			end
			draw(2, stall);
			ready_r = (stall != 0);  // Stalls about one cycle in four
		end
	end

endmodule

`default_nettype wire

/* dv/tb_blob_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tracking_params.svh"

module tb_blob_tracker import blob_mem_pkg::*, blob_track_pkg::*; ();

	localparam int NCASE = 3;
	localparam int NREC = 8;
	localparam int MEM_AW = 6;
	localparam int MEM_WORDS = 2**MEM_AW;
	localparam int TIMEOUT = 2000;

	logic clk;
	logic rst;
	logic start;
	logic done;
	rec_idx_t blob_count;
	logic mode;
	metric_t min_size;
	mem_req_t mem_req;
	logic mem_req_valid;
	logic mem_req_ready;
	mem_rsp_t mem_rsp;
	logic mem_rsp_valid;
	centroid_t cent;
	logic cent_valid;
	logic cent_ready = 1'b0;
	logic [15:0] lfsr = 16'd34;
	int errors;
	int timeouts;
	mem_word_t exp_mem [MEM_WORDS];
	centroid_t exp_q[$];
	centroid_t got_q[$];

	// Blob count, mode, min_size and expected stream length per case
	rec_idx_t case_count [NCASE] = '{16'd8, 16'd6, 16'd5};
	logic case_mode [NCASE] = '{1'b0, 1'b1, 1'b0};
	metric_t case_min [NCASE] = '{16'd10, 16'd0, 16'd0};
	int case_exp_n [NCASE] = '{3, 3, 2};

	// Each record packs tag, size, height, x and y
	logic [47:0] recs [NCASE][NREC] = '{
		'{48'h01_0064_32_0A_0B, 48'h01_00C8_28_0C_0D, 48'h01_00C8_3C_0E_0F,
		  48'h00_0384_10_20_21, 48'h09_0384_10_22_23, 48'h04_000A_05_24_25,
		  48'h06_0032_07_26_27, 48'h03_000B_08_28_29},
		'{48'h02_01F4_82_30_31, 48'h02_000A_64_32_33, 48'h02_0014_5A_34_35,
		  48'h04_0005_78_36_37, 48'h04_0005_79_38_39, 48'h05_0007_01_3A_3B,
		  48'h0, 48'h0},
		'{48'h06_0003_00_40_41, 48'h06_0009_00_42_43, 48'h01_0001_00_44_45,
		  48'h02_0000_00_46_47, 48'h06_0009_00_48_49, 48'h0, 48'h0, 48'h0}
	};

	blob_tracker_top u_blob_tracker_top (
		.clk(clk),
		.rst(rst),
		.start(start),
		.done(done),
		.blob_count(blob_count),
		.mode(mode),
		.min_size(min_size),
		.mem_req(mem_req),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_rsp(mem_rsp),
		.mem_rsp_valid(mem_rsp_valid),
		.cent(cent),
		.cent_valid(cent_valid),
		.cent_ready(cent_ready)
	);

	blob_mem_model #(.AW(MEM_AW)) u_mem (
		.clk(clk),
		.rst(rst),
		.req(mem_req),
		.req_valid(mem_req_valid),
		.req_ready(mem_req_ready),
		.rsp(mem_rsp),
		.rsp_valid(mem_rsp_valid)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Random back-pressure on the centroid stream
	always @(posedge clk) begin
		#1;
		lfsr = lfsr_next(lfsr);
		cent_ready = lfsr[0];
	end

	always @(posedge clk) begin
		if (cent_valid && cent_ready) got_q.push_back(cent);
	end

	task automatic load_case(input int k);
		logic [47:0] r;
		for (int a = 0; a < MEM_WORDS; a++) begin
			exp_mem[a] = 32'hC3C3_0000 | 32'(a);  // Fill outside the records
		end
		for (int i = 0; i < int'(case_count[k]); i++) begin
			r = recs[k][i];
			exp_mem[`RECORD_BASE + 3*i] = {24'h0, r[47:40]};
			exp_mem[`RECORD_BASE + 3*i + 1] = {8'h0, r[23:16], r[39:24]};
			exp_mem[`RECORD_BASE + 3*i + 2] = {r[15:8], r[7:0], r[39:24]};
		end
		for (int a = 0; a < MEM_WORDS; a++) begin
			u_mem.mem[a] = exp_mem[a];
		end
	endtask

	// Best blob per colour that beats min_size and every earlier blob
	task automatic build_expected(input int k);
		logic [47:0] r;
		metric_t m;
		metric_t best_m;
		int best;
		centroid_t c;
		exp_q.delete();
		for (int col = 0; col < `NUM_COLORS; col++) begin
			best = -1;
			best_m = case_min[k];
			for (int i = 0; i < int'(case_count[k]); i++) begin
				r = recs[k][i];
				if (r[47:40] == 8'(col + 1)) begin
					if (case_mode[k])
						m = (r[23:16] > 8'(`MAX_HEIGHT)) ? 16'd0 : {8'd0, r[23:16]};
					else
						m = r[39:24];
					if (m > best_m) begin
						best = i;
						best_m = m;
					end
				end
			end
			if (best >= 0) begin
				r = recs[k][best];
				c.color = color_t'(col);
				c.x = r[15:8];
				c.y = r[7:0];
				c.size = r[39:24];
				exp_q.push_back(c);
				exp_mem[`RECORD_BASE + 3*best + 2][15:0] = 16'h0;  // Consumed
			end
		end
	endtask

	task automatic check_case(input int k);
		if (got_q.size() != exp_q.size() || got_q.size() != case_exp_n[k]) begin
			errors++;
			$display("FAILED at %0t: case %0d streamed %0d centroids, expected %0d",
				$time, k, got_q.size(), case_exp_n[k]);
		end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			if (got_q[i] !== exp_q[i]) begin
				errors++;
				$display("FAILED at %0t: case %0d centroid %0d is %h, expected %h",
					$time, k, i, got_q[i], exp_q[i]);
			end
		end
		for (int a = 0; a < MEM_WORDS; a++) begin
			if (u_mem.mem[a] !== exp_mem[a]) begin
				errors++;
				$display("FAILED at %0t: case %0d memory word %0d is %h, expected %h",
					$time, k, a, u_mem.mem[a], exp_mem[a]);
			end
		end
	endtask

	initial begin
		int n;
		errors = 0;
		timeouts = 0;
		rst = 1'b1;
		start = 1'b0;
		blob_count = '0;
		mode = 1'b0;
		min_size = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		if (done || cent_valid) begin
			errors++;
			$display("FAILED at %0t: done or cent_valid high after reset", $time);
		end
		for (int k = 0; k < NCASE && timeouts == 0; k++) begin
			load_case(k);
			build_expected(k);
			got_q.delete();
			blob_count = case_count[k];
			mode = case_mode[k];
			min_size = case_min[k];
			start = 1'b1;
			n = 0;
			while (!done && n < TIMEOUT) begin
				@(posedge clk);
				#1;
				n++;
			end
			if (!done) begin
				timeouts++;
				$display("Timeout: done did not rise in case %0d", k);
			end else begin
				check_case(k);
				start = 1'b0;
				n = 0;
				while (done && n < TIMEOUT) begin
					@(posedge clk);
					#1;
					n++;
				end
				if (done) begin
					timeouts++;
					$display("Timeout: done stayed high after start dropped in case %0d", k);
				end
			end
		end
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/blob_mem_pkg.sv
common/blob_track_pkg.sv
scan/rank_table.sv
scan/blob_scanner.sv
src/tracker_ctrl.sv
src/centroid_fetch.sv
src/blob_tracker_top.sv
dv/blob_mem_model.sv
dv/tb_blob_tracker.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_blob_tracker -Mdir obj_dir
	./obj_dir/Vtb_blob_tracker | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
